// File: compile.f
rtl/lsu_pkg.sv
rtl/lsu_agu.sv
rtl/lsu_store_buffer.sv
rtl/lsu_load_unit.sv
rtl/lsu_data_ram.sv
rtl/memory_system.sv
test/lsu_checker.sv
test/tb_memory_system.sv

// File: rtl/lsu_agu.sv
// Address generation stage with alignment check, byte mask and store/load routing
`timescale 1ns/1ps
`default_nettype none

module lsu_agu (
    input  wire logic              cpu_clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              flush_i,
    input  wire lsu_pkg::mem_uop_t uop_i,
    input  wire logic              uop_vld_i,
    output lsu_pkg::agu_out_t      agu_o,
    output logic                   st_enq_o,
    output logic                   ld_req_o,
    output logic                   exc_vld_o,
    output lsu_pkg::exc_t          exc_o
);
    logic [lsu_pkg::XLEN-1:0] addr;
    logic                     is_store;
    logic                     misalign;
    logic                     accept;
    lsu_pkg::agu_out_t        agu_d;

    always_comb begin
        addr     = uop_i.base + uop_i.imm;
        is_store = uop_i.op[3];
        misalign = (uop_i.op[1:0] == 2'd1 && addr[0]) ||
                   (uop_i.op[1:0] == 2'd2 && addr[1:0] != 2'b00);

        agu_d       = '0;
        agu_d.op    = uop_i.op;
        agu_d.waddr = addr[lsu_pkg::RAM_AW+1:2];
        agu_d.boff  = addr[1:0];
        agu_d.sdata = uop_i.sdata << {addr[1:0], 3'b000};
        agu_d.dest  = uop_i.dest;
        agu_d.rob   = uop_i.rob;
        case (uop_i.op[1:0])
            2'd0:    agu_d.bmask = 4'b0001 << addr[1:0];
            2'd1:    agu_d.bmask = 4'b0011 << addr[1:0];
            default: agu_d.bmask = 4'b1111;
        endcase
    end

    // A micro-op arriving with a flush is dropped
    assign accept = uop_vld_i && !flush_i;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            st_enq_o  <= 1'b0;
            ld_req_o  <= 1'b0;
            exc_vld_o <= 1'b0;
        end else begin
            st_enq_o  <= accept && is_store && !misalign;
            ld_req_o  <= accept && !is_store && !misalign;
            exc_vld_o <= accept && misalign;
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (uop_vld_i) begin
            agu_o      <= agu_d;
            exc_o.rob  <= uop_i.rob;
            exc_o.code <= is_store ? lsu_pkg::EXC_ST_MISALIGN : lsu_pkg::EXC_LD_MISALIGN;
            exc_o.addr <= addr;
        end
    end

    a_one_route: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        $onehot0({st_enq_o, ld_req_o, exc_vld_o}))
        else $error("AGU routed one micro-op to more than one place");

endmodule

`default_nettype wire

// File: rtl/lsu_data_ram.sv
// Word data RAM with byte-masked write port and registered read port
`timescale 1ns/1ps
`default_nettype none

module lsu_data_ram (
    input  wire logic                       cpu_clk_i,
    input  wire logic                       we_i,
    input  wire logic [lsu_pkg::RAM_AW-1:0] waddr_i,
    input  wire logic [lsu_pkg::XLEN-1:0]   wdata_i,
    input  wire logic [3:0]                 wmask_i,
    input  wire logic                       re_i,
    input  wire logic [lsu_pkg::RAM_AW-1:0] raddr_i,
    output logic [lsu_pkg::XLEN-1:0]        rdata_o
);
    localparam int DEPTH = 2 ** lsu_pkg::RAM_AW;

    logic [lsu_pkg::XLEN-1:0] mem_q [DEPTH] = '{default: '0};

    always_ff @(posedge cpu_clk_i) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                if (wmask_i[b]) begin
                    mem_q[waddr_i][8*b +: 8] <= wdata_i[8*b +: 8];
                end
            end
        end
        // Read returns the old word on a same-address write
        if (re_i) begin
            rdata_o <= mem_q[raddr_i];
        end
    end

endmodule

`default_nettype wire

// File: rtl/lsu_load_unit.sv
// Load unit holding one load, resolving it by forwarding or RAM read, with extension
`timescale 1ns/1ps
`default_nettype none

module lsu_load_unit (
    input  wire logic                       cpu_clk_i,
    input  wire logic                       rst_n_i,
    input  wire logic                       flush_i,
    input  wire lsu_pkg::agu_out_t          ld_i,
    input  wire logic                       ld_vld_i,
    input  wire logic                       fwd_hit_i,
    input  wire logic                       fwd_conflict_i,
    input  wire logic [lsu_pkg::XLEN-1:0]   fwd_data_i,
    input  wire logic [lsu_pkg::XLEN-1:0]   ram_rdata_i,
    output logic [lsu_pkg::RAM_AW-1:0]      fwd_addr_o,
    output logic [3:0]                      fwd_mask_o,
    output logic                            ram_re_o,
    output logic [lsu_pkg::RAM_AW-1:0]      ram_raddr_o,
    output logic                            busy_o,
    output logic                            wb_vld_o,
    output lsu_pkg::wb_t                    wb_o,
    output logic                            cmp_vld_o,
    output logic [lsu_pkg::ROB_W-1:0]       cmp_rob_o
);
    typedef enum logic [1:0] {LU_IDLE, LU_LOOKUP, LU_RAM} lu_state_e;

    lu_state_e                state_q;
    lsu_pkg::agu_out_t        ld_q;
    logic                     take_fwd;
    logic [lsu_pkg::XLEN-1:0] word;
    logic [lsu_pkg::XLEN-1:0] lane;
    logic                     sext;

    assign busy_o      = state_q != LU_IDLE;
    assign fwd_addr_o  = ld_q.waddr;
    assign fwd_mask_o  = ld_q.bmask;
    assign ram_raddr_o = ld_q.waddr;

    assign take_fwd = state_q == LU_LOOKUP && fwd_hit_i;
    // No overlap at all means the RAM already holds the data
    assign ram_re_o = state_q == LU_LOOKUP && !fwd_hit_i && !fwd_conflict_i && !flush_i;
    assign wb_vld_o = (take_fwd || state_q == LU_RAM) && !flush_i;

    always_comb begin
        word      = take_fwd ? fwd_data_i : ram_rdata_i;
        lane      = word >> {ld_q.boff, 3'b000};
        sext      = !ld_q.op[2];
        wb_o.dest = ld_q.dest;
        case (ld_q.op[1:0])
            2'd0:    wb_o.data = {{24{sext & lane[7]}}, lane[7:0]};
            2'd1:    wb_o.data = {{16{sext & lane[15]}}, lane[15:0]};
            default: wb_o.data = word;
        endcase
    end

    assign cmp_vld_o = wb_vld_o;
    assign cmp_rob_o = ld_q.rob;

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q <= LU_IDLE;
        end else if (flush_i) begin
            state_q <= LU_IDLE;
        end else begin
            case (state_q)
                LU_IDLE:   state_q <= ld_vld_i ? LU_LOOKUP : LU_IDLE;
                LU_LOOKUP: begin
                    // A conflict holds here until the older store drains
                    if (fwd_hit_i) begin
                        state_q <= LU_IDLE;
                    end else if (!fwd_conflict_i) begin
                        state_q <= LU_RAM;
                    end
                end
                default:   state_q <= LU_IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (ld_vld_i && !busy_o) begin
            ld_q <= ld_i;
        end
    end

    a_no_load_while_busy: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        ld_vld_i |-> !busy_o)
        else $error("load request reached a busy load unit");

endmodule

`default_nettype wire

// File: rtl/lsu_pkg.sv
// Load/store unit package: sizes, opcode and exception codes, micro-op and stage structs
`default_nettype none

package lsu_pkg;

    localparam int XLEN       = 32;
    localparam int ROB_W      = 5;
    localparam int PREG_W     = 6;
    localparam int RAM_AW     = 8;
    localparam int SB_ENTRIES = 8;

    // Bit 3 marks a store, bit 2 an unsigned load, bits 1:0 give the access size
    typedef enum logic [3:0] {
        OP_LB  = 4'b0000,
        OP_LH  = 4'b0001,
        OP_LW  = 4'b0010,
        OP_LBU = 4'b0100,
        OP_LHU = 4'b0101,
        OP_SB  = 4'b1000,
        OP_SH  = 4'b1001,
        OP_SW  = 4'b1010
    } mem_op_e;

    localparam logic [3:0] EXC_LD_MISALIGN = 4'd4;
    localparam logic [3:0] EXC_ST_MISALIGN = 4'd6;

    typedef struct packed {
        mem_op_e           op;
        logic [XLEN-1:0]   base;
        logic [XLEN-1:0]   imm;
        logic [XLEN-1:0]   sdata;
        logic [PREG_W-1:0] dest;
        logic [ROB_W-1:0]  rob;
    } mem_uop_t;

    // Store data already sits in its byte lanes
    typedef struct packed {
        mem_op_e           op;
        logic [RAM_AW-1:0] waddr;
        logic [1:0]        boff;
        logic [3:0]        bmask;
        logic [XLEN-1:0]   sdata;
        logic [PREG_W-1:0] dest;
        logic [ROB_W-1:0]  rob;
    } agu_out_t;

    typedef struct packed {
        logic [PREG_W-1:0] dest;
        logic [XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic [ROB_W-1:0]  rob;
        logic [3:0]        code;
        logic [XLEN-1:0]   addr;
    } exc_t;

endpackage

`default_nettype wire

// File: rtl/lsu_store_buffer.sv
// Store buffer FIFO with commit pointer, RAM drain and load forwarding lookup
`timescale 1ns/1ps
`default_nettype none

module lsu_store_buffer #(
    parameter int ENTRIES = lsu_pkg::SB_ENTRIES
) (
    input  wire logic                        cpu_clk_i,
    input  wire logic                        rst_n_i,
    input  wire logic                        flush_i,
    input  wire lsu_pkg::agu_out_t           enq_i,
    input  wire logic                        enq_vld_i,
    input  wire logic                        commit_i,
    input  wire logic [lsu_pkg::RAM_AW-1:0]  fwd_addr_i,
    input  wire logic [3:0]                  fwd_mask_i,
    output logic                             cmp_vld_o,
    output logic [lsu_pkg::ROB_W-1:0]        cmp_rob_o,
    output logic                             fwd_hit_o,
    output logic                             fwd_conflict_o,
    output logic [lsu_pkg::XLEN-1:0]         fwd_data_o,
    output logic                             ram_we_o,
    output logic [lsu_pkg::RAM_AW-1:0]       ram_addr_o,
    output logic [lsu_pkg::XLEN-1:0]         ram_wdata_o,
    output logic [3:0]                       ram_wmask_o,
    output logic                             almost_full_o,
    output logic                             empty_o
);
    // ENTRIES is a power of two so the index wraps on its own
    localparam int IDX_W = $clog2(ENTRIES);

    logic [lsu_pkg::RAM_AW-1:0] addr_q [ENTRIES];
    logic [lsu_pkg::XLEN-1:0]   data_q [ENTRIES];
    logic [3:0]                 mask_q [ENTRIES];

    // Pointers carry one wrap bit; head..cmt is committed, cmt..tail is not
    logic [IDX_W:0]   head_q;
    logic [IDX_W:0]   cmt_q;
    logic [IDX_W:0]   tail_q;
    logic [IDX_W:0]   count;
    logic             enq_go;
    logic [IDX_W-1:0] idx;
    logic [IDX_W-1:0] young;
    logic             found;
    logic             covered;

    assign count    = tail_q - head_q;
    assign enq_go   = enq_vld_i && !flush_i;
    assign ram_we_o = head_q != cmt_q;

    assign cmp_vld_o = enq_go;
    assign cmp_rob_o = enq_i.rob;

    assign almost_full_o = int'(count) >= ENTRIES - 1;
    assign empty_o       = head_q == tail_q;

    assign ram_addr_o  = addr_q[head_q[IDX_W-1:0]];
    assign ram_wdata_o = data_q[head_q[IDX_W-1:0]];
    assign ram_wmask_o = mask_q[head_q[IDX_W-1:0]];

    // Youngest overlapping entry decides the lookup
    always_comb begin
        found = 1'b0;
        young = '0;
        for (int i = ENTRIES - 1; i >= 0; i--) begin
            idx = head_q[IDX_W-1:0] + IDX_W'(i);
            if (!found && i < int'(count) && addr_q[idx] == fwd_addr_i &&
                (mask_q[idx] & fwd_mask_i) != 4'b0000) begin
                found = 1'b1;
                young = idx;
            end
        end
        covered        = (mask_q[young] & fwd_mask_i) == fwd_mask_i;
        fwd_hit_o      = found && covered;
        fwd_conflict_o = found && !covered;
        fwd_data_o     = data_q[young];
    end

    always_ff @(posedge cpu_clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            head_q <= '0;
            cmt_q  <= '0;
            tail_q <= '0;
        end else begin
            if (ram_we_o) begin
                head_q <= head_q + 1'b1;
            end
            if (commit_i) begin
                cmt_q <= cmt_q + 1'b1;
            end
            // Flush drops only the stores the ROB has not retired
            if (flush_i) begin
                tail_q <= commit_i ? cmt_q + 1'b1 : cmt_q;
            end else if (enq_go) begin
                tail_q <= tail_q + 1'b1;
            end
        end
    end

    always_ff @(posedge cpu_clk_i) begin
        if (enq_go) begin
            addr_q[tail_q[IDX_W-1:0]] <= enq_i.waddr;
            data_q[tail_q[IDX_W-1:0]] <= enq_i.sdata;
            mask_q[tail_q[IDX_W-1:0]] <= enq_i.bmask;
        end
    end

    a_no_overflow: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        enq_vld_i |-> int'(count) < ENTRIES)
        else $error("store enqueued into a full store buffer");

    a_commit_in_range: assert property (@(posedge cpu_clk_i) disable iff (!rst_n_i)
        commit_i |-> cmt_q != tail_q)
        else $error("commit with no uncommitted store in the buffer");

endmodule

`default_nettype wire

// File: rtl/memory_system.sv
// Load/store subsystem top: AGU, store buffer, load unit and data RAM
`timescale 1ns/1ps
`default_nettype none

module memory_system (
    input  wire logic              cpu_clk_i,
    input  wire logic              rst_n_i,
    input  wire logic              flush_i,
    input  wire lsu_pkg::mem_uop_t mem_uop_i,
    input  wire logic              mem_vld_i,
    input  wire logic              commit_i,
    output logic                   full_o,
    output logic                   wb_vld_o,
    output lsu_pkg::wb_t           wb_o,
    output logic                   cmp_vld_o,
    output logic [lsu_pkg::ROB_W-1:0] cmp_rob_o,
    output logic                   ld_cmp_vld_o,
    output logic [lsu_pkg::ROB_W-1:0] ld_cmp_rob_o,
    output logic                   exception_o,
    output lsu_pkg::exc_t          exc_o,
    output logic                   stb_emp_o
);
    lsu_pkg::agu_out_t          agu_out;
    logic                       st_enq;
    logic                       ld_req;
    logic                       fwd_hit;
    logic                       fwd_conflict;
    logic [lsu_pkg::XLEN-1:0]   fwd_data;
    logic [lsu_pkg::RAM_AW-1:0] fwd_addr;
    logic [3:0]                 fwd_mask;
    logic                       ram_we;
    logic [lsu_pkg::RAM_AW-1:0] ram_waddr;
    logic [lsu_pkg::XLEN-1:0]   ram_wdata;
    logic [3:0]                 ram_wmask;
    logic                       ram_re;
    logic [lsu_pkg::RAM_AW-1:0] ram_raddr;
    logic [lsu_pkg::XLEN-1:0]   ram_rdata;
    logic                       lu_busy;
    logic                       sb_almost_full;

    lsu_agu i_agu (
        .cpu_clk_i (cpu_clk_i),
        .rst_n_i   (rst_n_i),
        .flush_i   (flush_i),
        .uop_i     (mem_uop_i),
        .uop_vld_i (mem_vld_i),
        .agu_o     (agu_out),
        .st_enq_o  (st_enq),
        .ld_req_o  (ld_req),
        .exc_vld_o (exception_o),
        .exc_o     (exc_o)
    );

    lsu_store_buffer #(
        .ENTRIES (lsu_pkg::SB_ENTRIES)
    ) i_stb (
        .cpu_clk_i      (cpu_clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .enq_i          (agu_out),
        .enq_vld_i      (st_enq),
        .commit_i       (commit_i),
        .fwd_addr_i     (fwd_addr),
        .fwd_mask_i     (fwd_mask),
        .cmp_vld_o      (cmp_vld_o),
        .cmp_rob_o      (cmp_rob_o),
        .fwd_hit_o      (fwd_hit),
        .fwd_conflict_o (fwd_conflict),
        .fwd_data_o     (fwd_data),
        .ram_we_o       (ram_we),
        .ram_addr_o     (ram_waddr),
        .ram_wdata_o    (ram_wdata),
        .ram_wmask_o    (ram_wmask),
        .almost_full_o  (sb_almost_full),
        .empty_o        (stb_emp_o)
    );

    lsu_load_unit i_ldu (
        .cpu_clk_i      (cpu_clk_i),
        .rst_n_i        (rst_n_i),
        .flush_i        (flush_i),
        .ld_i           (agu_out),
        .ld_vld_i       (ld_req),
        .fwd_hit_i      (fwd_hit),
        .fwd_conflict_i (fwd_conflict),
        .fwd_data_i     (fwd_data),
        .ram_rdata_i    (ram_rdata),
        .fwd_addr_o     (fwd_addr),
        .fwd_mask_o     (fwd_mask),
        .ram_re_o       (ram_re),
        .ram_raddr_o    (ram_raddr),
        .busy_o         (lu_busy),
        .wb_vld_o       (wb_vld_o),
        .wb_o           (wb_o),
        .cmp_vld_o      (ld_cmp_vld_o),
        .cmp_rob_o      (ld_cmp_rob_o)
    );

    lsu_data_ram i_ram (
        .cpu_clk_i (cpu_clk_i),
        .we_i      (ram_we),
        .waddr_i   (ram_waddr),
        .wdata_i   (ram_wdata),
        .wmask_i   (ram_wmask),
        .re_i      (ram_re),
        .raddr_i   (ram_raddr),
        .rdata_o   (ram_rdata)
    );

    // One load in flight at a time, and room kept for a store still in the AGU
    assign full_o = lu_busy || ld_req || sb_almost_full;

endmodule

`default_nettype wire

// File: run.sh
#!/bin/sh
# Build and run the memory_system testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_memory_system \
    -f compile.f -o tb_memory_system || exit 1
./obj_dir/tb_memory_system > sim.log 2>&1
cat sim.log
grep -qF '*** PASSED ***' sim.log && exit 0 || exit 1

// File: test/lsu_checker.sv
// Monitor that compares writebacks, completions and exceptions with the expected records
`timescale 1ns/1ps
`default_nettype none

module lsu_checker (
    input  wire logic                       clk_i,
    input  wire logic                       req_i,
    input  wire logic [31:0]                id_i,
    input  wire logic [31:0]                kind_i,
    input  wire logic [lsu_pkg::PREG_W-1:0] dest_i,
    input  wire logic [lsu_pkg::ROB_W-1:0]  rob_i,
    input  wire logic [31:0]                x_i,
    input  wire logic [31:0]                y_i,
    input  wire logic                       wb_vld_i,
    input  wire lsu_pkg::wb_t               wb_i,
    input  wire logic                       cmp_vld_i,
    input  wire logic [lsu_pkg::ROB_W-1:0]  cmp_rob_i,
    input  wire logic                       ld_cmp_vld_i,
    input  wire logic [lsu_pkg::ROB_W-1:0]  ld_cmp_rob_i,
    input  wire logic                       exc_vld_i,
    input  wire lsu_pkg::exc_t              exc_i,
    output int                              done_o,
    output int                              pass_o,
    output int                              fail_o
);
    int errs;

    task automatic compare_field(input string name, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH test %0d %s: got 0x%h, expected 0x%h", id_i, name, got, exp);
            errs++;
        end
    endtask

    // Writebacks and completions may take a while, so wait for the first one
    task automatic wait_event();
        int   cycles;
        logic seen;
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < 200) begin
            @(posedge clk_i);
            cycles++;
            seen = (kind_i == "wb") ? wb_vld_i : cmp_vld_i;
        end
        if (!seen) begin
            $display("test %0d: no writeback or completion arrived within 200 cycles", id_i);
            errs++;
        end else if (kind_i == "wb") begin
            compare_field("wb_o.dest", 32'(wb_i.dest), 32'(dest_i));
            compare_field("wb_o.data", wb_i.data, y_i);
            compare_field("ld_cmp_vld_o", 32'(ld_cmp_vld_i), 32'd1);
            compare_field("ld_cmp_rob_o", 32'(ld_cmp_rob_i), 32'(rob_i));
            if (x_i != 0) begin
                compare_field("wb_vld_o latency", 32'(cycles), x_i);
            end
        end else begin
            compare_field("cmp_rob_o", 32'(cmp_rob_i), 32'(rob_i));
        end
    endtask

    // Fixed window in which only the expected exception may show up
    task automatic watch_window();
        int   cycles;
        int   limit;
        logic seen;
        seen  = 1'b0;
        limit = (kind_i == "exc") ? 4 : int'(x_i);
        for (cycles = 0; cycles < limit; cycles++) begin
            @(posedge clk_i);
            if (wb_vld_i || cmp_vld_i || ld_cmp_vld_i) begin
                $display("test %0d: unexpected writeback or completion", id_i);
                errs++;
            end
            if (exc_vld_i) begin
                if (kind_i != "exc" || seen) begin
                    $display("test %0d: unexpected exception", id_i);
                    errs++;
                end else begin
                    seen = 1'b1;
                    compare_field("exc_o.rob", 32'(exc_i.rob), 32'(rob_i));
                    compare_field("exc_o.code", 32'(exc_i.code), x_i);
                    compare_field("exc_o.addr", exc_i.addr, y_i);
                end
            end
        end
        if (kind_i == "exc" && !seen) begin
            $display("test %0d: no exception was raised", id_i);
            errs++;
        end
    endtask

    initial begin
        done_o = 0;
        pass_o = 0;
        fail_o = 0;
        forever begin
            @(posedge clk_i);
            if (req_i) begin
                errs = 0;
                if (kind_i == "wb" || kind_i == "cmp") begin
                    wait_event();
                end else begin
                    watch_window();
                end
                if (errs == 0) begin
                    $display("test %0d: pass", id_i);
                    pass_o++;
                end else begin
                    $display("test %0d: fail", id_i);
                    fail_o++;
                end
                done_o++;
            end
        end
    end

endmodule

`default_nettype wire

// File: test/memory_system_tests.txt
# id action op base imm sdata dest rob kind x y  (all hex except id)
# wb: x latency (0 any), y data; exc: x code, y address; none: x cycles watched
1  issue  a 00000100 00000010 87654321 00 01 cmp  0 00000000
2  commit 0 00000000 00000000 00000000 00 00 none 4 00000000
3  drain  0 00000000 00000000 00000000 00 00 none 0 00000000
4  issue  2 00000100 00000010 00000000 05 02 wb   3 87654321
5  issue  0 00000100 00000013 00000000 06 03 wb   3 ffffff87
6  issue  4 00000100 00000013 00000000 07 04 wb   3 00000087
7  issue  1 00000100 00000012 00000000 08 05 wb   3 ffff8765
8  issue  5 00000100 00000012 00000000 09 06 wb   3 00008765
9  issue  0 00000100 00000010 00000000 0a 07 wb   3 00000021
10 issue  a 00000200 00000000 cafef00d 00 08 cmp  0 00000000
11 issue  2 00000200 00000000 00000000 0b 09 wb   2 cafef00d
12 commit 0 00000000 00000000 00000000 00 00 none 4 00000000
13 drain  0 00000000 00000000 00000000 00 00 none 0 00000000
14 issue  8 00000100 00000011 000000aa 00 0a cmp  0 00000000
15 issue  2 00000100 00000010 00000000 0c 0b none 4 00000000
16 commit 0 00000000 00000000 00000000 0c 0b wb   0 8765aa21
17 drain  0 00000000 00000000 00000000 00 00 none 0 00000000
18 issue  2 00000100 00000012 00000000 0d 0c exc  4 00000112
19 issue  9 00000100 00000013 00001234 00 0d exc  6 00000113
20 issue  2 00000100 00000010 00000000 0e 0e wb   3 8765aa21
21 issue  a 00000300 00000000 11111111 00 0f cmp  0 00000000
22 issue  9 00000300 00000002 00002222 00 10 cmp  0 00000000
23 flush  0 00000000 00000000 00000000 00 00 none 4 00000000
24 drain  0 00000000 00000000 00000000 00 00 none 0 00000000
25 issue  2 00000300 00000000 00000000 0f 11 wb   3 00000000
26 issue  a 00000380 00000000 a0000000 00 12 cmp  0 00000000
27 issue  a 00000380 00000004 a0000001 00 13 cmp  0 00000000
28 issue  a 00000380 00000008 a0000002 00 14 cmp  0 00000000
29 issue  a 00000380 0000000c a0000003 00 15 cmp  0 00000000
30 issue  a 00000380 00000010 a0000004 00 16 cmp  0 00000000
31 issue  a 00000380 00000014 a0000005 00 17 cmp  0 00000000
32 issue  a 00000380 00000018 a0000006 00 18 cmp  0 00000000
33 commit 0 00000000 00000000 00000000 00 00 none 0 00000000
34 issue  a 00000380 0000001c a0000007 00 19 cmp  0 00000000
35 commit 0 00000000 00000000 00000000 00 00 none 4 00000000
36 commit 0 00000000 00000000 00000000 00 00 none 4 00000000
37 commit 0 00000000 00000000 00000000 00 00 none 4 00000000
38 commit 0 00000000 00000000 00000000 00 00 none 4 00000000
39 commit 0 00000000 00000000 00000000 00 00 none 4 00000000
40 commit 0 00000000 00000000 00000000 00 00 none 4 00000000
41 commit 0 00000000 00000000 00000000 00 00 none 4 00000000
42 drain  0 00000000 00000000 00000000 00 00 none 0 00000000
43 issue  2 00000380 0000001c 00000000 10 1a wb   3 a0000007

// File: test/tb_memory_system.sv
// Testbench top: clock, reset, stimulus from the tests file on falling edges, summary
`timescale 1ns/1ps
`default_nettype none

module tb_memory_system;
    logic                      clk;
    logic                      rst_n;
    logic                      flush;
    lsu_pkg::mem_uop_t         uop;
    logic                      mem_vld;
    logic                      commit;
    logic                      full;
    logic                      wb_vld;
    lsu_pkg::wb_t              wb;
    logic                      cmp_vld;
    logic [lsu_pkg::ROB_W-1:0] cmp_rob;
    logic                      ld_cmp_vld;
    logic [lsu_pkg::ROB_W-1:0] ld_cmp_rob;
    logic                      exc_vld;
    lsu_pkg::exc_t             exc;
    logic                      stb_emp;

    // Expectation handed to the checker
    logic                       req;
    logic [31:0]                exp_id;
    logic [31:0]                exp_kind;
    logic [lsu_pkg::PREG_W-1:0] exp_dest;
    logic [lsu_pkg::ROB_W-1:0]  exp_rob;
    logic [31:0]                exp_x;
    logic [31:0]                exp_y;
    int                         done_cnt;
    int                         chk_pass;
    int                         chk_fail;

    int          fd;
    string       line;
    int          id;
    logic [63:0] act;
    logic [63:0] kind;
    logic [31:0] op_f;
    logic [31:0] base_f;
    logic [31:0] imm_f;
    logic [31:0] sdata_f;
    logic [31:0] dest_f;
    logic [31:0] rob_f;
    logic [31:0] x_f;
    logic [31:0] y_f;
    int          own_pass;
    int          own_fail;
    int          throttled;
    logic        stop;

    memory_system i_dut (
        .cpu_clk_i    (clk),
        .rst_n_i      (rst_n),
        .flush_i      (flush),
        .mem_uop_i    (uop),
        .mem_vld_i    (mem_vld),
        .commit_i     (commit),
        .full_o       (full),
        .wb_vld_o     (wb_vld),
        .wb_o         (wb),
        .cmp_vld_o    (cmp_vld),
        .cmp_rob_o    (cmp_rob),
        .ld_cmp_vld_o (ld_cmp_vld),
        .ld_cmp_rob_o (ld_cmp_rob),
        .exception_o  (exc_vld),
        .exc_o        (exc),
        .stb_emp_o    (stb_emp)
    );

    lsu_checker i_checker (
        .clk_i        (clk),
        .req_i        (req),
        .id_i         (exp_id),
        .kind_i       (exp_kind),
        .dest_i       (exp_dest),
        .rob_i        (exp_rob),
        .x_i          (exp_x),
        .y_i          (exp_y),
        .wb_vld_i     (wb_vld),
        .wb_i         (wb),
        .cmp_vld_i    (cmp_vld),
        .cmp_rob_i    (cmp_rob),
        .ld_cmp_vld_i (ld_cmp_vld),
        .ld_cmp_rob_i (ld_cmp_rob),
        .exc_vld_i    (exc_vld),
        .exc_i        (exc),
        .done_o       (done_cnt),
        .pass_o       (chk_pass),
        .fail_o       (chk_fail)
    );

    always #5 clk = ~clk;

    // An empty store buffer with no load in flight leaves full_o low
    task automatic wait_drain();
        int n;
        n = 0;
        while (!stb_emp && n < 100) begin
            @(negedge clk);
            n++;
        end
        if (stb_emp && !full) begin
            $display("test %0d: pass", id);
            own_pass++;
        end else if (stb_emp) begin
            $display("MISMATCH test %0d full_o: got 0x%h, expected 0x0", id, full);
            own_fail++;
        end else begin
            $display("test %0d: store buffer did not drain within 100 cycles", id);
            own_fail++;
        end
    endtask

    // Drives one line for a cycle and waits for the checker's verdict
    task automatic apply_line();
        int n;
        int start;
        n = 0;
        if (act == "issue") begin
            if (full) begin
                throttled++;
            end
            while (full && n < 100) begin
                @(negedge clk);
                n++;
            end
            if (full) begin
                $display("test %0d: full_o stayed high for 100 cycles", id);
                own_fail++;
                stop = 1'b1;
            end
        end
        if (!stop) begin
            exp_id    = 32'(id);
            exp_kind  = kind[31:0];
            exp_dest  = dest_f[lsu_pkg::PREG_W-1:0];
            exp_rob   = rob_f[lsu_pkg::ROB_W-1:0];
            exp_x     = x_f;
            exp_y     = y_f;
            uop.op    = lsu_pkg::mem_op_e'(op_f[3:0]);
            uop.base  = base_f;
            uop.imm   = imm_f;
            uop.sdata = sdata_f;
            uop.dest  = dest_f[lsu_pkg::PREG_W-1:0];
            uop.rob   = rob_f[lsu_pkg::ROB_W-1:0];
            mem_vld   = act == "issue";
            commit    = act == "commit";
            flush     = act == "flush";
            req       = 1'b1;
            start     = done_cnt;
            @(negedge clk);
            mem_vld = 1'b0;
            commit  = 1'b0;
            flush   = 1'b0;
            n = 0;
            while (done_cnt == start && n < 300) begin
                @(negedge clk);
                n++;
            end
            req = 1'b0;
            if (done_cnt == start) begin
                $display("test %0d: checker gave no verdict within 300 cycles", id);
                own_fail++;
                stop = 1'b1;
            end
        end
    endtask

    initial begin
        clk       = 1'b0;
        rst_n     = 1'b0;
        flush     = 1'b0;
        uop       = '0;
        mem_vld   = 1'b0;
        commit    = 1'b0;
        req       = 1'b0;
        exp_id    = '0;
        exp_kind  = '0;
        exp_dest  = '0;
        exp_rob   = '0;
        exp_x     = '0;
        exp_y     = '0;
        own_pass  = 0;
        own_fail  = 0;
        throttled = 0;
        stop      = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        fd = $fopen("test/memory_system_tests.txt", "r");
        if (fd == 0) begin
            $display("cannot open test/memory_system_tests.txt");
            own_fail++;
            stop = 1'b1;
        end
        // Comment and blank lines do not scan to a full record
        while (!stop && $fgets(line, fd) != 0) begin
            if ($sscanf(line, "%d %s %h %h %h %h %h %h %s %h %h", id, act, op_f, base_f,
                        imm_f, sdata_f, dest_f, rob_f, kind, x_f, y_f) == 11) begin
                if (act == "drain") begin
                    wait_drain();
                end else begin
                    apply_line();
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        // A full store buffer must hold back at least one issue
        if (!stop && throttled == 0) begin
            $display("full_o never held back an issued micro-op");
            own_fail++;
        end

        $display("tests: %0d run, %0d passed, %0d failed",
                 chk_pass + chk_fail + own_pass + own_fail,
                 chk_pass + own_pass, chk_fail + own_fail);
        if (chk_fail + own_fail == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire
